// ==== compile.f ====
+incdir+src
src/cpu_pkg.sv
src/regfile.sv
src/instr_fetch.sv
src/decode_issue.sv
src/instr_exec.sv
src/mem_writeback.sv
src/cpu_core.sv
sim/cpu_core_assertions.sv
sim/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f compile.f --top-module tb_cpu_core
./obj_dir/Vtb_cpu_core > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
	echo "simulation stopped before the end of the tests"
	exit 1
fi

// ==== sim/cpu_core_assertions.sv ====
`timescale 1ns/1ps

module cpu_core_assertions (
	input logic               clk,
	input logic               rst,
	input logic               ibus_valid_i,
	input logic               ibus_ready_i,
	input cpu_pkg::bus_req_t  ibus_req_i,
	input logic               ibus_rvalid_i,
	input logic               dbus_valid_i,
	input logic               dbus_ready_i,
	input cpu_pkg::bus_req_t  dbus_req_i,
	input logic               dbus_rvalid_i,
	input logic               wb_en_i,
	input cpu_pkg::reg_addr_t wb_addr_i
);

	// requests wait unchanged for ready
	ibus_hold: assert property (@(posedge clk) disable iff (rst)
		ibus_valid_i && !ibus_ready_i |=> ibus_valid_i && $stable(ibus_req_i))
		else $error("ibus request changed before it was accepted");

	dbus_hold: assert property (@(posedge clk) disable iff (rst)
		dbus_valid_i && !dbus_ready_i |=> dbus_valid_i && $stable(dbus_req_i))
		else $error("dbus request changed before it was accepted");

	// one request outstanding, so none is raised while its response is due
	ibus_resp: assert property (@(posedge clk) disable iff (rst)
		ibus_rvalid_i |-> $past(ibus_valid_i && ibus_ready_i) && !ibus_valid_i)
		else $error("ibus response not matched to a single accepted request");

	dbus_resp: assert property (@(posedge clk) disable iff (rst)
		dbus_rvalid_i |-> $past(dbus_valid_i && dbus_ready_i) && !dbus_valid_i)
		else $error("dbus response not matched to a single accepted request");

	wb_zero: assert property (@(posedge clk) disable iff (rst)
		!(wb_en_i && wb_addr_i == 5'd0))
		else $error("write to register zero enabled");

endmodule

bind cpu_core cpu_core_assertions i_assertions (
	.clk           ( clk           ),
	.rst           ( rst           ),
	.ibus_valid_i  ( ibus_valid_o  ),
	.ibus_ready_i  ( ibus_ready_i  ),
	.ibus_req_i    ( ibus_req_o    ),
	.ibus_rvalid_i ( ibus_rvalid_i ),
	.dbus_valid_i  ( dbus_valid_o  ),
	.dbus_ready_i  ( dbus_ready_i  ),
	.dbus_req_i    ( dbus_req_o    ),
	.dbus_rvalid_i ( dbus_rvalid_i ),
	.wb_en_i       ( wb_en         ),
	.wb_addr_i     ( wb_addr       )
);

// ==== sim/tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu_core;

	import cpu_pkg::*;

	logic        clk;
	logic        rst;
	logic        ibus_valid_o;
	logic        ibus_ready_i;
	bus_req_t    ibus_req_o;
	logic        ibus_rvalid_i;
	logic [31:0] ibus_rdata_i;
	logic        dbus_valid_o;
	logic        dbus_ready_i;
	bus_req_t    dbus_req_o;
	logic        dbus_rvalid_i;
	logic [31:0] dbus_rdata_i;

	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	logic [31:0] prog [$];
	logic        ib_acc, db_acc, end_seen, stall_en;
	logic [31:0] ib_data, db_data;
	logic [31:0] op_a, op_b, op_c, op_k, mul_a, mul_b;
	integer      seed = 32'h69e3d575;
	int          budget = 0;
	int          cycles = 0;
	int          errors = 0;

	cpu_core i_dut (
		.clk,
		.rst,
		.ibus_valid_o,
		.ibus_ready_i,
		.ibus_req_o,
		.ibus_rvalid_i,
		.ibus_rdata_i,
		.dbus_valid_o,
		.dbus_ready_i,
		.dbus_req_o,
		.dbus_rvalid_i,
		.dbus_rdata_i
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// bus models sample requests on the rising edge
	always @(posedge clk) begin
		ib_acc  = !rst && ibus_valid_o && ibus_ready_i;
		ib_data = imem[ibus_req_o.addr[11:2]];
		db_acc  = !rst && dbus_valid_o && dbus_ready_i;
		db_data = dmem[dbus_req_o.addr[11:2]];
		if (db_acc && dbus_req_o.we) begin
			dmem[dbus_req_o.addr[11:2]] = dbus_req_o.wdata;
			if (dbus_req_o.addr == 32'h0000_0100)
				end_seen = 1'b1;
		end
	end

	// responses one cycle after acceptance
	initial begin
		ibus_ready_i  = 1'b0;
		ibus_rvalid_i = 1'b0;
		ibus_rdata_i  = '0;
		dbus_ready_i  = 1'b0;
		dbus_rvalid_i = 1'b0;
		dbus_rdata_i  = '0;
		forever begin
			@(negedge clk);
			ibus_rvalid_i = ib_acc;
			ibus_rdata_i  = ib_data;
			dbus_rvalid_i = db_acc;
			dbus_rdata_i  = db_data;
			ibus_ready_i  = !stall_en || (($random(seed) & 3) != 0);
			dbus_ready_i  = !stall_en || (($random(seed) & 3) != 0);
		end
	end

	initial begin
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the final store never came", cycles);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] rtype(logic [5:0] funct, int rd, int rs, int rt);
		return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'h00, funct};
	endfunction

	function automatic logic [31:0] itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] fill_word(int idx);
		logic [31:0] a;
		a = idx * 4;
		return {~a[15:0], a[15:0]};
	endfunction

	// unsigned product by shift and add
	function automatic logic [63:0] shift_add_mul(input logic [31:0] a, input logic [31:0] b);
		logic [63:0] acc;
		acc = '0;
		for (int k = 0; k < 32; k++) begin
			if (b[k])
				acc += {32'h0, a} << k;
		end
		return acc;
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic load_const(input int r, input logic [31:0] v);
		emit(itype(`OP_LUI, 0, r, v[31:16]));
		emit(itype(`OP_ORI, r, r, v[15:0]));
	endtask

	task automatic store(input int rt, input int addr);
		emit(itype(`OP_SW, 0, rt, addr[15:0]));
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_word(input int addr, input logic [31:0] want);
		check($sformatf("dmem[%03h]", addr[11:0]), dmem[addr[11:2]], want);
	endtask

	// memories are loaded while the core sits in reset
	task automatic run_program(input logic stall);
		store(0, 'h100);
		budget += prog.size() * 40;
		@(negedge clk);
		rst      = 1'b1;
		stall_en = stall;
		end_seen = 1'b0;
		for (int k = 0; k < 1024; k++) begin
			imem[k[9:0]] = (k < prog.size()) ? prog[k] : 32'h0;
			dmem[k[9:0]] = fill_word(k);
		end
		repeat (3) @(negedge clk);
		rst = 1'b0;
		while (!end_seen)
			@(negedge clk);
	endtask

	task automatic alu_chain(input logic [31:0] a, b, c, input logic stall);
		logic [31:0] x [12];
		x[0]  = '0;
		x[1]  = a;
		x[2]  = b;
		x[3]  = c;
		x[4]  = a + b;
		x[5]  = x[4] - c;
		x[6]  = x[5] & a;
		x[7]  = x[6] | b;
		x[8]  = x[7] ^ x[5];
		x[9]  = ($signed(x[8]) < $signed(c)) ? 32'd1 : 32'd0;
		x[10] = ($signed(c) < $signed(x[8])) ? 32'd1 : 32'd0;
		x[11] = x[8] + 32'hffff_fffb;
		prog.delete();
		load_const(1, a);
		load_const(2, b);
		load_const(3, c);
		emit(rtype(`FUNCT_ADDU, 4, 1, 2));
		emit(rtype(`FUNCT_SUBU, 5, 4, 3));
		emit(rtype(`FUNCT_AND, 6, 5, 1));
		emit(rtype(`FUNCT_OR, 7, 6, 2));
		emit(rtype(`FUNCT_XOR, 8, 7, 5));
		emit(rtype(`FUNCT_SLT, 9, 8, 3));
		emit(rtype(`FUNCT_SLT, 10, 3, 8));
		emit(itype(`OP_ADDIU, 8, 11, 16'hfffb));
		for (int r = 1; r < 12; r++)
			store(r, 'h200 + r * 4);
		run_program(stall);
		for (int r = 1; r < 12; r++)
			check_word('h200 + r * 4, x[r[3:0]]);
	endtask

	task automatic load_use(input logic [31:0] k);
		logic [31:0] w;
		w = fill_word('h300 >> 2);
		prog.delete();
		load_const(2, k);
		emit(itype(`OP_LW, 0, 1, 16'h0300));
		emit(rtype(`FUNCT_ADDU, 3, 1, 2));
		emit(itype(`OP_LW, 0, 4, 16'h0300));
		emit(rtype(`FUNCT_ADDU, 5, 4, 4));
		store(3, 'h304);
		store(5, 'h308);
		// reload a word the core just stored, then store it at once
		emit(itype(`OP_LW, 0, 6, 16'h0304));
		store(6, 'h30c);
		run_program(1'b0);
		check_word('h304, w + k);
		check_word('h308, w + w);
		check_word('h30c, w + k);
	endtask

	task automatic branches();
		prog.delete();
		emit(itype(`OP_ADDIU, 0, 1, 16'd5));
		emit(itype(`OP_ADDIU, 0, 2, 16'd5));
		emit(itype(`OP_ADDIU, 0, 3, 16'd7));
		emit(itype(`OP_BEQ, 1, 2, 16'd2));
		store(3, 'h400);
		store(3, 'h404);
		store(1, 'h408);
		emit(itype(`OP_BNE, 1, 2, 16'd1));
		store(3, 'h40c);
		emit(itype(`OP_BNE, 1, 3, 16'd1));
		store(3, 'h410);
		emit(itype(`OP_BEQ, 1, 3, 16'd1));
		store(2, 'h414);
		// count down from 3, summing into r5
		emit(itype(`OP_ADDIU, 0, 4, 16'd3));
		emit(rtype(`FUNCT_ADDU, 5, 5, 4));
		emit(itype(`OP_ADDIU, 4, 4, 16'hffff));
		emit(itype(`OP_BNE, 4, 0, 16'hfffd));
		store(5, 'h418);
		run_program(1'b0);
		check_word('h400, fill_word('h400 >> 2));
		check_word('h404, fill_word('h404 >> 2));
		check_word('h408, 32'd5);
		check_word('h40c, 32'd7);
		check_word('h410, fill_word('h410 >> 2));
		check_word('h414, 32'd5);
		check_word('h418, 32'd6);
	endtask

	task automatic multiply(input logic [31:0] a, b);
		logic [63:0] p, q;
		p = shift_add_mul(a, b);
		q = shift_add_mul(b, b);
		prog.delete();
		load_const(1, a);
		load_const(2, b);
		emit(rtype(`FUNCT_MULTU, 0, 1, 2));
		emit(rtype(`FUNCT_MFHI, 3, 0, 0));
		emit(rtype(`FUNCT_MFLO, 4, 0, 0));
		emit(rtype(`FUNCT_MULTU, 0, 2, 2));
		emit(rtype(`FUNCT_MFLO, 5, 0, 0));
		emit(rtype(`FUNCT_MFHI, 6, 0, 0));
		store(3, 'h500);
		store(4, 'h504);
		store(5, 'h508);
		store(6, 'h50c);
		run_program(1'b0);
		check_word('h500, p[63:32]);
		check_word('h504, p[31:0]);
		check_word('h508, q[31:0]);
		check_word('h50c, q[63:32]);
	endtask

	task automatic zero_reg();
		prog.delete();
		emit(itype(`OP_ADDIU, 0, 0, 16'h1234));
		emit(rtype(`FUNCT_ADDU, 1, 0, 0));
		emit(itype(`OP_LUI, 0, 0, 16'hbeef));
		emit(itype(`OP_ADDIU, 0, 2, 16'h0022));
		store(0, 'h600);
		store(1, 'h604);
		store(2, 'h608);
		run_program(1'b0);
		check_word('h600, 32'h0);
		check_word('h604, 32'h0);
		check_word('h608, 32'h22);
	endtask

	initial begin
		rst      = 1'b1;
		stall_en = 1'b0;
		end_seen = 1'b0;
		// all operands drawn before the bus models start using the seed
		op_a  = $random(seed);
		op_b  = $random(seed);
		op_c  = $random(seed);
		op_k  = $random(seed);
		mul_a = $random(seed);
		mul_b = $random(seed);
		alu_chain(op_a, op_b, op_c, 1'b0);
		load_use(op_k);
		branches();
		multiply(mul_a, mul_b);
		alu_chain(op_a, op_b, op_c, 1'b1);
		zero_reg();
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== src/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_RESET_PC 32'h0000_0000
`define REG_NUM      32

// primary opcodes
`define OP_SPECIAL   6'h00
`define OP_BEQ       6'h04
`define OP_BNE       6'h05
`define OP_ADDIU     6'h09
`define OP_ORI       6'h0d
`define OP_LUI       6'h0f
`define OP_LW        6'h23
`define OP_SW        6'h2b

// SPECIAL function codes
`define FUNCT_MFHI   6'h10
`define FUNCT_MFLO   6'h12
`define FUNCT_MULTU  6'h19
`define FUNCT_ADDU   6'h21
`define FUNCT_SUBU   6'h23
`define FUNCT_AND    6'h24
`define FUNCT_OR     6'h25
`define FUNCT_XOR    6'h26
`define FUNCT_SLT    6'h2a

`endif

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
	input  logic              clk,
	input  logic              rst,
	output logic              ibus_valid_o,
	input  logic              ibus_ready_i,
	output cpu_pkg::bus_req_t ibus_req_o,
	input  logic              ibus_rvalid_i,
	input  logic [31:0]       ibus_rdata_i,
	output logic              dbus_valid_o,
	input  logic              dbus_ready_i,
	output cpu_pkg::bus_req_t dbus_req_o,
	input  logic              dbus_rvalid_i,
	input  logic [31:0]       dbus_rdata_i
);

	import cpu_pkg::*;

	redirect_t    redirect;
	fetch_entry_t if_entry;
	decode_t      id_entry;
	exec_t        ex_entry;
	logic         if_valid, id_ready, id_valid, ex_ready, ex_valid, mw_ready;
	reg_addr_t    raddr_a, raddr_b, wb_addr;
	logic [31:0]  rdata_a, rdata_b, wb_data;
	logic         wb_en;

	regfile regfile_inst (
		.clk,
		.rst,
		.raddr_a_i ( raddr_a ),
		.raddr_b_i ( raddr_b ),
		.rdata_a_o ( rdata_a ),
		.rdata_b_o ( rdata_b ),
		.we_i      ( wb_en   ),
		.waddr_i   ( wb_addr ),
		.wdata_i   ( wb_data )
	);

	instr_fetch instr_fetch_inst (
		.clk,
		.rst,
		.redirect_i  ( redirect ),
		.ibus_valid_o,
		.ibus_ready_i,
		.ibus_req_o,
		.ibus_rvalid_i,
		.ibus_rdata_i,
		.out_valid_o ( if_valid ),
		.out_ready_i ( id_ready ),
		.out_o       ( if_entry )
	);

	decode_issue decode_issue_inst (
		.clk,
		.rst,
		.flush_i          ( redirect.valid ),
		.in_valid_i       ( if_valid       ),
		.in_ready_o       ( id_ready       ),
		.in_i             ( if_entry       ),
		.raddr_a_o        ( raddr_a        ),
		.raddr_b_o        ( raddr_b        ),
		.rdata_a_i        ( rdata_a        ),
		.rdata_b_i        ( rdata_b        ),
		.fwd_exec_i       ( ex_entry       ),
		.fwd_exec_valid_i ( ex_valid       ),
		.wb_en_i          ( wb_en          ),
		.wb_addr_i        ( wb_addr        ),
		.wb_data_i        ( wb_data        ),
		.out_valid_o      ( id_valid       ),
		.out_ready_i      ( ex_ready       ),
		.out_o            ( id_entry       )
	);

	instr_exec instr_exec_inst (
		.clk,
		.rst,
		.in_valid_i  ( id_valid ),
		.in_ready_o  ( ex_ready ),
		.in_i        ( id_entry ),
		.redirect_o  ( redirect ),
		.out_valid_o ( ex_valid ),
		.out_ready_i ( mw_ready ),
		.out_o       ( ex_entry )
	);

	mem_writeback mem_writeback_inst (
		.clk,
		.rst,
		.in_valid_i ( ex_valid ),
		.in_ready_o ( mw_ready ),
		.in_i       ( ex_entry ),
		.dbus_valid_o,
		.dbus_ready_i,
		.dbus_req_o,
		.dbus_rvalid_i,
		.dbus_rdata_i,
		.wb_en_o    ( wb_en    ),
		.wb_addr_o  ( wb_addr  ),
		.wb_data_o  ( wb_data  )
	);

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [4:0] reg_addr_t;

	// one word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			reg_addr_t  rs;
			reg_addr_t  rt;
			reg_addr_t  rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			reg_addr_t   rs;
			reg_addr_t   rt;
			logic [15:0] imm;
		} i;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	typedef struct packed {
		logic [31:0] pc;
		instr_t      instr;
	} fetch_entry_t;

	// b holds the immediate for I-type, store_data the rt value
	typedef struct packed {
		logic [31:0] pc;
		alu_op_e     alu_op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] store_data;
		reg_addr_t   rd;
		logic        is_load;
		logic        is_store;
		logic        is_branch_eq;
		logic        is_branch_ne;
		logic        is_mult;
		logic        is_mfhi;
		logic        is_mflo;
		logic        wb_en;
	} decode_t;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] store_data;
		reg_addr_t   rd;
		logic        is_load;
		logic        is_store;
		logic        wb_en;
	} exec_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        we;
	} bus_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

endpackage

// ==== src/decode_issue.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_issue (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush_i,
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  cpu_pkg::fetch_entry_t in_i,
	output cpu_pkg::reg_addr_t    raddr_a_o,
	output cpu_pkg::reg_addr_t    raddr_b_o,
	input  logic [31:0]           rdata_a_i,
	input  logic [31:0]           rdata_b_i,
	input  cpu_pkg::exec_t        fwd_exec_i,
	input  logic                  fwd_exec_valid_i,
	input  logic                  wb_en_i,
	input  cpu_pkg::reg_addr_t    wb_addr_i,
	input  logic [31:0]           wb_data_i,
	output logic                  out_valid_o,
	input  logic                  out_ready_i,
	output cpu_pkg::decode_t      out_o
);

	import cpu_pkg::*;

	instr_t      ins;
	decode_t     d, out_q;
	logic        out_valid_q, use_rs, use_rt, wb, hold;
	logic [31:0] rs_val, rt_val, sext, zext;

	// exec result first, then writeback, then the register file
	function automatic logic [31:0] fwd(input reg_addr_t addr, input logic [31:0] rf_val);
		logic [31:0] v;
		v = rf_val;
		if (wb_en_i && wb_addr_i == addr)
			v = wb_data_i;
		if (fwd_exec_valid_i && fwd_exec_i.wb_en && !fwd_exec_i.is_load && fwd_exec_i.rd == addr)
			v = fwd_exec_i.result;
		return v;
	endfunction

	function automatic logic depends(input reg_addr_t rd);
		return (use_rs && ins.i.rs == rd) || (use_rt && ins.i.rt == rd);
	endfunction

	assign ins       = in_i.instr;
	assign raddr_a_o = ins.i.rs;
	assign raddr_b_o = ins.i.rt;
	assign rs_val    = fwd(ins.i.rs, rdata_a_i);
	assign rt_val    = fwd(ins.i.rt, rdata_b_i);
	assign sext      = {{16{ins.i.imm[15]}}, ins.i.imm};
	assign zext      = {16'h0, ins.i.imm};

	always_comb begin
		d            = '0;
		d.pc         = in_i.pc;
		d.alu_op     = ALU_ADD;
		d.a          = rs_val;
		d.b          = sext;
		d.store_data = rt_val;
		d.rd         = ins.i.rt;
		use_rs       = 1'b1;
		use_rt       = 1'b0;
		wb           = 1'b0;
		case (ins.i.op)
			`OP_SPECIAL: begin
				d.b    = rt_val;
				d.rd   = ins.r.rd;
				use_rt = 1'b1;
				case (ins.r.funct)
					`FUNCT_ADDU: wb = 1'b1;
					`FUNCT_SUBU: begin d.alu_op = ALU_SUB; wb = 1'b1; end
					`FUNCT_AND:  begin d.alu_op = ALU_AND; wb = 1'b1; end
					`FUNCT_OR:   begin d.alu_op = ALU_OR;  wb = 1'b1; end
					`FUNCT_XOR:  begin d.alu_op = ALU_XOR; wb = 1'b1; end
					`FUNCT_SLT:  begin d.alu_op = ALU_SLT; wb = 1'b1; end
					`FUNCT_MULTU: d.is_mult = 1'b1;
					`FUNCT_MFHI: begin d.is_mfhi = 1'b1; wb = 1'b1; use_rs = 1'b0; use_rt = 1'b0; end
					`FUNCT_MFLO: begin d.is_mflo = 1'b1; wb = 1'b1; use_rs = 1'b0; use_rt = 1'b0; end
					default: use_rt = 1'b0;
				endcase
			end
			`OP_ADDIU: wb = 1'b1;
			`OP_ORI: begin
				d.alu_op = ALU_OR;
				d.b      = zext;
				wb       = 1'b1;
			end
			`OP_LUI: begin
				d.alu_op = ALU_OR;
				d.a      = '0;
				d.b      = {ins.i.imm, 16'h0};
				wb       = 1'b1;
				use_rs   = 1'b0;
			end
			`OP_LW: begin d.is_load = 1'b1; wb = 1'b1; end
			`OP_SW: begin d.is_store = 1'b1; use_rt = 1'b1; end
			`OP_BEQ: begin d.is_branch_eq = 1'b1; use_rt = 1'b1; end
			`OP_BNE: begin d.is_branch_ne = 1'b1; use_rt = 1'b1; end
			default: use_rs = 1'b0;
		endcase
		d.wb_en = wb && d.rd != '0;
	end

	// load in exec output until its data is on the writeback port,
	// or any producer still in our own output register
	assign hold = (fwd_exec_valid_i && fwd_exec_i.is_load && fwd_exec_i.wb_en
			&& !wb_en_i && depends(fwd_exec_i.rd))
		|| (out_valid_q && out_q.wb_en && depends(out_q.rd));

	assign in_ready_o  = (~out_valid_q | out_ready_i) & ~hold;
	assign out_valid_o = out_valid_q;
	assign out_o       = out_q;

	always_ff @(posedge clk) begin
		if (rst || flush_i)
			out_valid_q <= 1'b0;
		else if (in_valid_i && in_ready_o)
			out_valid_q <= 1'b1;
		else if (out_ready_i)
			out_valid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o)
			out_q <= d;
	end

endmodule

// ==== src/instr_exec.sv ====
`timescale 1ns/1ps

module instr_exec (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid_i,
	output logic               in_ready_o,
	input  cpu_pkg::decode_t   in_i,
	output cpu_pkg::redirect_t redirect_o,
	output logic               out_valid_o,
	input  logic               out_ready_i,
	output cpu_pkg::exec_t     out_o
);

	import cpu_pkg::*;

	exec_t       out_q, res;
	logic        out_valid_q, fire, taken;
	logic [31:0] alu;
	logic [63:0] hilo_q, product;

	assign in_ready_o = ~out_valid_q | out_ready_i;
	assign fire       = in_valid_i & in_ready_o;

	// memory address is a + b as well
	always_comb begin
		case (in_i.alu_op)
			ALU_SUB: alu = in_i.a - in_i.b;
			ALU_AND: alu = in_i.a & in_i.b;
			ALU_OR:  alu = in_i.a | in_i.b;
			ALU_XOR: alu = in_i.a ^ in_i.b;
			ALU_SLT: alu = {31'h0, $signed(in_i.a) < $signed(in_i.b)};
			default: alu = in_i.a + in_i.b;
		endcase
	end

	assign product = {32'h0, in_i.a} * {32'h0, in_i.b};

	always_comb begin
		res            = '0;
		res.result     = alu;
		res.store_data = in_i.store_data;
		res.rd         = in_i.rd;
		res.is_load    = in_i.is_load;
		res.is_store   = in_i.is_store;
		res.wb_en      = in_i.wb_en;
		if (in_i.is_mfhi)
			res.result = hilo_q[63:32];
		else if (in_i.is_mflo)
			res.result = hilo_q[31:0];
	end

	// branches compare rs against rt, which rides in store_data
	assign taken = (in_i.is_branch_eq && in_i.a == in_i.store_data)
		|| (in_i.is_branch_ne && in_i.a != in_i.store_data);

	assign redirect_o.valid  = fire & taken;
	assign redirect_o.target = in_i.pc + 32'd4 + {in_i.b[29:0], 2'b00};

	assign out_valid_o = out_valid_q;
	assign out_o       = out_q;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid_q <= 1'b0;
		else if (fire)
			out_valid_q <= 1'b1;
		else if (out_ready_i)
			out_valid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fire)
			out_q <= res;
		if (fire && in_i.is_mult)
			hilo_q <= product;
	end

endmodule

// ==== src/instr_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_fetch (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::redirect_t    redirect_i,
	output logic                  ibus_valid_o,
	input  logic                  ibus_ready_i,
	output cpu_pkg::bus_req_t     ibus_req_o,
	input  logic                  ibus_rvalid_i,
	input  logic [31:0]           ibus_rdata_i,
	output logic                  out_valid_o,
	input  logic                  out_ready_i,
	output cpu_pkg::fetch_entry_t out_o
);

	import cpu_pkg::*;

	logic [31:0]  pc_q, req_addr_q, wait_pc_q, fetch_addr;
	logic         req_valid_q, wait_q, stale_q, buf_valid_q;
	fetch_entry_t buf_q;
	logic         resp_ok, buf_next, launch, req_fire;

	// response of a live request
	assign resp_ok = wait_q & ibus_rvalid_i & ~stale_q;

	assign out_valid_o = buf_valid_q | resp_ok;
	always_comb begin
		out_o = buf_q;
		if (!buf_valid_q) begin
			out_o.pc    = wait_pc_q;
			out_o.instr = ibus_rdata_i;
		end
	end

	assign buf_next   = ~redirect_i.valid & out_valid_o & ~out_ready_i;
	assign launch     = ~req_valid_q & (~wait_q | ibus_rvalid_i) & ~buf_next;
	assign fetch_addr = redirect_i.valid ? redirect_i.target : pc_q;
	assign req_fire   = req_valid_q & ibus_ready_i;

	assign ibus_valid_o     = req_valid_q;
	assign ibus_req_o.addr  = req_addr_q;
	assign ibus_req_o.wdata = '0;
	assign ibus_req_o.we    = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q        <= `CPU_RESET_PC;
			req_valid_q <= 1'b0;
			wait_q      <= 1'b0;
			stale_q     <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			buf_valid_q <= buf_next;
			if (launch) begin
				req_valid_q <= 1'b1;
				pc_q        <= fetch_addr + 32'd4;
			end else begin
				if (redirect_i.valid)
					pc_q <= redirect_i.target;
				if (req_fire)
					req_valid_q <= 1'b0;
			end
			if (req_fire)
				wait_q <= 1'b1;
			else if (ibus_rvalid_i)
				wait_q <= 1'b0;
			// a request issued before the redirect belongs to the old path
			if (redirect_i.valid)
				stale_q <= req_valid_q;
			else if (wait_q && ibus_rvalid_i)
				stale_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (launch)
			req_addr_q <= fetch_addr;
		if (req_fire)
			wait_pc_q <= req_addr_q;
		if (buf_next && !buf_valid_q)
			buf_q <= out_o;
	end

endmodule

// ==== src/mem_writeback.sv ====
`timescale 1ns/1ps

module mem_writeback (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid_i,
	output logic               in_ready_o,
	input  cpu_pkg::exec_t     in_i,
	output logic               dbus_valid_o,
	input  logic               dbus_ready_i,
	output cpu_pkg::bus_req_t  dbus_req_o,
	input  logic               dbus_rvalid_i,
	input  logic [31:0]        dbus_rdata_i,
	output logic               wb_en_o,
	output cpu_pkg::reg_addr_t wb_addr_o,
	output logic [31:0]        wb_data_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_e;

	state_e state_q;
	logic   is_mem, idle, done;

	assign is_mem = in_i.is_load | in_i.is_store;
	assign idle   = state_q == ST_IDLE;
	assign done   = state_q == ST_WAIT && dbus_rvalid_i;

	// a memory entry stays in exec's output register until it completes
	assign dbus_valid_o     = state_q == ST_REQ || (idle && in_valid_i && is_mem);
	assign dbus_req_o.addr  = in_i.result;
	assign dbus_req_o.wdata = in_i.store_data;
	assign dbus_req_o.we    = in_i.is_store;

	assign in_ready_o = (idle & ~is_mem) | done;

	// ALU results retire as they arrive, loads on the response
	assign wb_en_o   = (idle && in_valid_i && !is_mem && in_i.wb_en)
		|| (done && in_i.is_load && in_i.wb_en);
	assign wb_addr_o = in_i.rd;
	assign wb_data_o = done ? dbus_rdata_i : in_i.result;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (dbus_valid_o)
						state_q <= dbus_ready_i ? ST_WAIT : ST_REQ;
				end
				ST_REQ: begin
					if (dbus_ready_i)
						state_q <= ST_WAIT;
				end
				ST_WAIT: begin
					if (dbus_rvalid_i)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regfile (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::reg_addr_t raddr_a_i,
	input  cpu_pkg::reg_addr_t raddr_b_i,
	output logic [31:0]       rdata_a_o,
	output logic [31:0]       rdata_b_o,
	input  logic              we_i,
	input  cpu_pkg::reg_addr_t waddr_i,
	input  logic [31:0]       wdata_i
);

	logic [31:0] regs [`REG_NUM];

	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < `REG_NUM; k++) begin
				regs[k] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule
